// File: all.f
src/mem_cfg_pkg.sv
src/mem_xact_pkg.sv
src/mem_arbiter.sv
src/req_delay.sv
src/line_store.sv
src/rsp_delay.sv
src/mem_top.sv
tb/mem_props.sv
tb/mem_top_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mem_top_tb -o mem_sim &&
./obj_dir/mem_sim | tee /dev/stderr | grep -q -F "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb/mem_input.txt
// columns: op, byte address, line (write data or expected read data), gap in cycles
// op 1 instr read, 2 data read, 3 data write, 4 paired read (data side, instr side follows)
3 100 00112233445566778899aabbccddeeff 0c
2 100 00112233445566778899aabbccddeeff 0c
3 ff8 0f0e0d0c0b0a09080706050403020100 0c
2 000 00000000000000000f0e0d0c0b0a0908 0c
1 ffc 000000000f0e0d0c0b0a090807060504 0c
3 200 8899aabbccddeeff0123456789abcdef 0c
4 100 00112233445566778899aabbccddeeff 00
1 200 8899aabbccddeeff0123456789abcdef 0c
3 300 fedcba98765432100f1e2d3c4b5a6978 01
1 300 fedcba98765432100f1e2d3c4b5a6978 0a
2 300 fedcba98765432100f1e2d3c4b5a6978 01
1 000 00000000000000000f0e0d0c0b0a0908 01
2 200 8899aabbccddeeff0123456789abcdef 0c
2 200 8899aabbccddeeff0123456789abcdef 0c
1 100 00112233445566778899aabbccddeeff 01
1 300 fedcba98765432100f1e2d3c4b5a6978 0c
0 000 00000000000000000000000000000000 00

// File: tb/mem_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top_tb
  import mem_cfg_pkg::*;
();

  // cycles from issue to the read strobe
  localparam int LAT     = REQ_LAT + 1 + RSP_LAT;
  localparam int MAX_REC = 32;

  logic  clk_i = 1'b0;
  logic  rst_i;
  logic  instr_req_i, data_req_i, data_we_i;
  addr_t instr_addr_i, data_addr_i;
  line_t data_wdata_i;
  logic  instr_busy_o, instr_rvalid_o, data_busy_o, data_rvalid_o;
  line_t instr_rdata_o, data_rdata_o;

  line_t rec_mem [4*MAX_REC];
  int    cyc = 0;
  int    nrec = 0;
  int    limit_cycles = 0;
  // first and last busy cycle expected on each port
  int    ib_from = 0, ib_end = -1, db_from = 0, db_end = -1;
  int    data_acc_cyc = -1;
  line_t iq[$], dq[$];
  int    iq_due[$], dq_due[$];
  int    n_instr_exp = 0, n_data_exp = 0, n_instr_got = 0, n_data_got = 0;

  mem_top dut (.*);

  bind mem_arbiter mem_props props_i (
    .clk_i(clk_i), .rst_i(rst_i), .instr_req_i(instr_req_i), .data_req_i(data_req_i),
    .instr_busy_i(instr_busy_o), .data_busy_i(data_busy_o),
    .issue_i(issue_o), .done_rsp_i(done_rsp_i)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic stop_on_error();
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_line(string name, line_t got, line_t exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(string name, bit got, bit exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("Fail at time %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // a strobe on a busy port is dropped, so nothing is queued for it
  task automatic strobe_data(bit we, addr_t addr, line_t line);
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_addr_i  = addr;
    data_wdata_i = we ? line : '0;
    if (cyc > db_end) begin
      db_from      = cyc + 1;
      db_end       = cyc + LAT;
      data_acc_cyc = cyc;
      if (!we) begin
        dq.push_back(line);
        dq_due.push_back(cyc + LAT);
        n_data_exp++;
      end
    end
  endtask

  task automatic strobe_instr(addr_t addr, line_t line);
    int extra;
    // loses a tie against the data port by one cycle
    extra        = (data_acc_cyc == cyc) ? 1 : 0;
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    if (cyc > ib_end) begin
      ib_from = cyc + 1;
      ib_end  = cyc + LAT + extra;
      iq.push_back(line);
      iq_due.push_back(cyc + LAT + extra);
      n_instr_exp++;
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_i) begin
      check_flag("instr_busy_o", instr_busy_o, cyc >= ib_from && cyc <= ib_end);
      check_flag("data_busy_o", data_busy_o, cyc >= db_from && cyc <= db_end);
      if (instr_rvalid_o) begin
        if (iq.size() == 0) begin
          $display("unexpected response on the instruction port at %0t", $time);
          stop_on_error();
        end else begin
          check_count("instr_rvalid_o cycle", cyc, iq_due.pop_front());
          check_line("instr_rdata_o", instr_rdata_o, iq.pop_front());
          n_instr_got++;
        end
      end
      if (data_rvalid_o) begin
        if (dq.size() == 0) begin
          $display("unexpected response on the data port at %0t", $time);
          stop_on_error();
        end else begin
          check_count("data_rvalid_o cycle", cyc, dq_due.pop_front());
          check_line("data_rdata_o", data_rdata_o, dq.pop_front());
          n_data_got++;
        end
      end
      if (dut.u_arbiter.props_i.fail_cnt != 0) begin
        $display("a bound assertion on the arbiter failed at %0t", $time);
        stop_on_error();
      end
    end
  end

  initial begin
    int    op;
    int    gap;
    int    r;
    addr_t addr;
    line_t line;
    rst_i        = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_we_i    = 1'b0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    for (int i = 0; i < 4*MAX_REC; i++) begin
      rec_mem[i] = '0;
    end
    $readmemh("tb/mem_input.txt", rec_mem);
    while (nrec < MAX_REC && rec_mem[4*nrec] != '0) begin
      nrec++;
    end
    for (int i = 0; i < nrec; i++) begin
      limit_cycles += int'(rec_mem[4*i+3][7:0]) + REQ_LAT + RSP_LAT + 4;
    end
    limit_cycles += 8;
    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b1;
    r = 0;
    while (r < nrec) begin
      op   = int'(rec_mem[4*r][3:0]);
      addr = rec_mem[4*r+1][ADDR_WIDTH-1:0];
      line = rec_mem[4*r+2];
      gap  = int'(rec_mem[4*r+3][7:0]);
      case (op)
        1: strobe_instr(addr, line);
        2: strobe_data(1'b0, addr, line);
        3: strobe_data(1'b1, addr, line);
        4: begin
          // instruction side comes from the next record in the same cycle
          strobe_data(1'b0, addr, line);
          r++;
          strobe_instr(rec_mem[4*r+1][ADDR_WIDTH-1:0], rec_mem[4*r+2]);
          gap = int'(rec_mem[4*r+3][7:0]);
        end
        default: begin
          $display("unknown op code %0d in record %0d of the input file", op, r);
          stop_on_error();
        end
      endcase
      r++;
      repeat (gap) begin
        @(posedge clk_i);
        #2;
        instr_req_i = 1'b0;
        data_req_i  = 1'b0;
        data_we_i   = 1'b0;
      end
    end
    wait (cyc > ib_end && cyc > db_end);
    @(negedge clk_i);
    check_count("instruction responses", n_instr_got, n_instr_exp);
    check_count("data responses", n_data_got, n_data_exp);
    $display("=== PASS ===");
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("timeout after %0d cycles, responses went missing", limit_cycles);
    stop_on_error();
  end

endmodule

`default_nettype wire

// File: tb/mem_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_props
  import mem_xact_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input logic     instr_req_i,
  input logic     data_req_i,
  input logic     instr_busy_i,
  input logic     data_busy_i,
  input mem_req_t issue_i,
  input mem_rsp_t done_rsp_i
);

  int fail_cnt = 0;

  // a data request only issues from an idle data port
  data_issue_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
    issue_i.valid && !issue_i.is_instr |-> !data_busy_i)
    else begin
      $error("data request issued while the data port was busy");
      fail_cnt++;
    end

  // an instruction request issues from an idle port or one cycle after a tie
  instr_issue_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
    issue_i.valid && issue_i.is_instr
    |-> !instr_busy_i || $past(instr_req_i && data_req_i && !instr_busy_i && !data_busy_i))
    else begin
      $error("instruction request issued while the instruction port was busy");
      fail_cnt++;
    end

  // a tie issues data now and the instruction one cycle later
  tie_one_per_cycle: assert property (@(posedge clk_i) disable iff (!rst_i)
    instr_req_i && data_req_i && !instr_busy_i && !data_busy_i
    |=> issue_i.valid && issue_i.is_instr)
    else begin
      $error("held instruction request was not issued alone in the next cycle");
      fail_cnt++;
    end

  instr_busy_fall: assert property (@(posedge clk_i) disable iff (!rst_i)
    $fell(instr_busy_i) |-> $past(done_rsp_i.valid && done_rsp_i.is_instr))
    else begin
      $error("instruction busy fell without an instruction response");
      fail_cnt++;
    end

  data_busy_fall: assert property (@(posedge clk_i) disable iff (!rst_i)
    $fell(data_busy_i) |-> $past(done_rsp_i.valid && !done_rsp_i.is_instr))
    else begin
      $error("data busy fell without a data response");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: src/mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top
  import mem_cfg_pkg::*;
  import mem_xact_pkg::*;
#(
  parameter int MEM_BYTES = mem_cfg_pkg::MEM_BYTES,
  parameter int REQ_LAT   = mem_cfg_pkg::REQ_LAT,
  parameter int RSP_LAT   = mem_cfg_pkg::RSP_LAT
) (
  input  logic  clk_i,
  input  logic  rst_i,

  // instruction port
  input  logic  instr_req_i,
  input  addr_t instr_addr_i,
  output logic  instr_busy_o,
  output logic  instr_rvalid_o,
  output line_t instr_rdata_o,

  // data port
  input  logic  data_req_i,
  input  logic  data_we_i,
  input  addr_t data_addr_i,
  input  line_t data_wdata_i,
  output logic  data_busy_o,
  output logic  data_rvalid_o,
  output line_t data_rdata_o
);

  mem_req_t issue;
  mem_req_t store_req;
  mem_rsp_t store_rsp;
  mem_rsp_t done_rsp;

  mem_arbiter u_arbiter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .data_req_i     (data_req_i),
    .data_we_i      (data_we_i),
    .data_addr_i    (data_addr_i),
    .data_wdata_i   (data_wdata_i),
    .done_rsp_i     (done_rsp),
    .issue_o        (issue),
    .instr_busy_o   (instr_busy_o),
    .data_busy_o    (data_busy_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o)
  );

  // access latency toward the store
  req_delay #(
    .REQ_LAT (REQ_LAT)
  ) u_req_delay (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (issue),
    .req_o (store_req)
  );

  line_store #(
    .MEM_BYTES (MEM_BYTES)
  ) u_line_store (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (store_req),
    .rsp_o (store_rsp)
  );

  // return latency back to the ports
  rsp_delay #(
    .RSP_LAT (RSP_LAT)
  ) u_rsp_delay (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .rsp_i (store_rsp),
    .rsp_o (done_rsp)
  );

endmodule

`default_nettype wire

// File: src/rsp_delay.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_delay
  import mem_xact_pkg::*;
#(
  parameter int RSP_LAT = 1
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_rsp_t rsp_i,
  output mem_rsp_t rsp_o
);

  mem_rsp_t stage_q [RSP_LAT];

  // tags and read data shift every cycle and reset clears the valid bits
  always_ff @(posedge clk_i) begin
    stage_q[0] <= rsp_i;
    for (int i = 1; i < RSP_LAT; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
    if (!rst_i) begin
      for (int i = 0; i < RSP_LAT; i++) begin
        stage_q[i].valid <= 1'b0;
      end
    end
  end

  assign rsp_o = stage_q[RSP_LAT-1];

endmodule

`default_nettype wire

// File: src/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store
  import mem_cfg_pkg::*;
  import mem_xact_pkg::*;
#(
  parameter int MEM_BYTES = mem_cfg_pkg::MEM_BYTES
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  // byte array cleared at start of simulation
  logic [7:0] mem [MEM_BYTES] = '{default: 8'h00};

  line_t    rd_line;
  mem_rsp_t rsp_q;

  // byte position inside the array with wrap at the top
  function automatic int byte_idx(addr_t base, int off);
    return (int'(base) + off) % MEM_BYTES;
  endfunction

  // gather a line with byte 0 in the low bits
  always_comb begin
    rd_line = '0;
    for (int i = 0; i < LINE_BYTES; i++) begin
      rd_line[i*8 +: 8] = mem[byte_idx(req_i.addr, i)];
    end
  end

  // write commits on the same edge a read is registered
  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.is_wr) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        mem[byte_idx(req_i.addr, i)] <= req_i.wdata[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      rsp_q.valid <= 1'b0;
    end else begin
      rsp_q.valid <= req_i.valid;
    end
    rsp_q.is_instr <= req_i.is_instr;
    rsp_q.is_wr    <= req_i.is_wr;
    // writes answer with an empty line
    rsp_q.rdata    <= req_i.is_wr ? '0 : rd_line;
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: src/req_delay.sv
`timescale 1ns/1ps
`default_nettype none

module req_delay
  import mem_xact_pkg::*;
#(
  parameter int REQ_LAT = 1
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_req_t req_i,
  output mem_req_t req_o
);

  mem_req_t stage_q [REQ_LAT];

  // requests shift every cycle and reset clears the valid bits
  always_ff @(posedge clk_i) begin
    stage_q[0] <= req_i;
    for (int i = 1; i < REQ_LAT; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
    if (!rst_i) begin
      for (int i = 0; i < REQ_LAT; i++) begin
        stage_q[i].valid <= 1'b0;
      end
    end
  end

  assign req_o = stage_q[REQ_LAT-1];

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
  import mem_cfg_pkg::*;
  import mem_xact_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  input  logic     instr_req_i,
  input  addr_t    instr_addr_i,

  input  logic     data_req_i,
  input  logic     data_we_i,
  input  addr_t    data_addr_i,
  input  line_t    data_wdata_i,

  input  mem_rsp_t done_rsp_i,

  output mem_req_t issue_o,
  output logic     instr_busy_o,
  output logic     data_busy_o,
  output logic     instr_rvalid_o,
  output line_t    instr_rdata_o,
  output logic     data_rvalid_o,
  output line_t    data_rdata_o
);

  arb_state_e state_q, state_d;
  addr_t      hold_addr_q;
  logic       instr_busy_q;
  logic       data_busy_q;

  logic       instr_acc;
  logic       data_acc;
  logic       instr_done;
  logic       data_done;

  // strobes on a busy port are dropped here
  assign instr_acc = instr_req_i && !instr_busy_q;
  assign data_acc  = data_req_i && !data_busy_q;

  assign instr_done = done_rsp_i.valid && done_rsp_i.is_instr;
  assign data_done  = done_rsp_i.valid && !done_rsp_i.is_instr;

  // issue select where the data port wins a tie
  always_comb begin
    issue_o = '0;
    state_d = ARB_IDLE;
    if (state_q == ARB_HOLD) begin
      // both ports are busy here, so nothing new can compete
      issue_o.valid    = 1'b1;
      issue_o.is_instr = 1'b1;
      issue_o.addr     = hold_addr_q;
    end else if (data_acc) begin
      issue_o.valid = 1'b1;
      issue_o.is_wr = data_we_i;
      issue_o.addr  = data_addr_i;
      issue_o.wdata = data_wdata_i;
      if (instr_acc) begin
        state_d = ARB_HOLD;
      end
    end else if (instr_acc) begin
      issue_o.valid    = 1'b1;
      issue_o.is_instr = 1'b1;
      issue_o.addr     = instr_addr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // deferred instruction address
  always_ff @(posedge clk_i) begin
    if (state_d == ARB_HOLD) begin
      hold_addr_q <= instr_addr_i;
    end
  end

  // one outstanding request per port
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      instr_busy_q <= 1'b0;
      data_busy_q  <= 1'b0;
    end else begin
      if (instr_acc) begin
        instr_busy_q <= 1'b1;
      end else if (instr_done) begin
        instr_busy_q <= 1'b0;
      end
      if (data_acc) begin
        data_busy_q <= 1'b1;
      end else if (data_done) begin
        data_busy_q <= 1'b0;
      end
    end
  end

  assign instr_busy_o = instr_busy_q;
  assign data_busy_o  = data_busy_q;

  // write completions only clear busy and never reach a port
  assign instr_rvalid_o = instr_done && !done_rsp_i.is_wr;
  assign data_rvalid_o  = data_done && !done_rsp_i.is_wr;

  assign instr_rdata_o = instr_rvalid_o ? done_rsp_i.rdata : '0;
  assign data_rdata_o  = data_rvalid_o ? done_rsp_i.rdata : '0;

endmodule

`default_nettype wire

// File: src/mem_xact_pkg.sv
`default_nettype none

package mem_xact_pkg;

  import mem_cfg_pkg::*;

  // request travelling from the arbiter to the store
  typedef struct packed {
    logic  valid;
    logic  is_instr;
    logic  is_wr;
    addr_t addr;
    line_t wdata;
  } mem_req_t;

  // response travelling from the store back to the arbiter
  typedef struct packed {
    logic  valid;
    logic  is_instr;
    logic  is_wr;
    line_t rdata;
  } mem_rsp_t;

  // ARB_HOLD parks an instruction request one cycle behind a data request
  typedef enum logic {
    ARB_IDLE,
    ARB_HOLD
  } arb_state_e;

endpackage

`default_nettype wire

// File: src/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

  // byte address width
  localparam int ADDR_WIDTH = 12;

  // bytes moved by one access
  localparam int LINE_BYTES = 16;

  // default store size in bytes
  localparam int MEM_BYTES = 4096;

  // default pipeline depths on each side of the store
  localparam int REQ_LAT = 5;
  localparam int RSP_LAT = 4;

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [LINE_BYTES*8-1:0] line_t;

endpackage

`default_nettype wire
